/* common/red_defines.svh */
// Reduction unit sizing macros for the lane count and the lane width

`ifndef RED_DEFINES_SVH
`define RED_DEFINES_SVH

// Number of parallel lanes in one wide word
// Any value of 1 or more works
`define RED_LANES 4

// Width of one lane in bits
// The wide word is RED_LANES times this
`define RED_LANE_W 64

`endif

/* common/red_pkg.sv */
// Reduction unit package with the operation encoding and the lane data type

`default_nettype none

package red_pkg;

  `include "red_defines.svh"

  // Reduction operation, one per request and shared by all lanes
  //   ADD   low 64 bits of op1 + op2
  //   MUL   low 64 bits of op1 * op2
  //   MAX   two's-complement maximum
  //   MIN   two's-complement minimum
  //   MAXU  unsigned maximum
  //   MINU  unsigned minimum
  //   AND   bitwise and
  //   OR    bitwise or
  typedef enum logic [2:0] {
    ADD  = 3'd0,
    MUL  = 3'd1,
    MAX  = 3'd2,
    MIN  = 3'd3,
    MAXU = 3'd4,
    MINU = 3'd5,
    AND  = 3'd6,
    OR   = 3'd7
  } red_op_e;

  // One lane word
  typedef logic [`RED_LANE_W-1:0] lane_data_t;

endpackage

`default_nettype wire

/* common/red_lane_if.sv */
// Per-lane request and response stream between the sync block and one ALU lane

`timescale 1ns/1ps
`default_nettype none

interface red_lane_if;

  import red_pkg::*;

  // Request stream, operands come straight from the top-level slices
  lane_data_t req_op1;
  lane_data_t req_op2;
  red_op_e    req_op;
  logic       req_valid;
  logic       req_ready;

  // Response stream
  lane_data_t resp_data;
  logic       resp_valid;
  logic       resp_ready;

  modport sync (
    output req_valid, resp_ready,
    input  req_ready, resp_valid, resp_data
  );

  modport lane (
    input  req_op1, req_op2, req_op, req_valid, resp_ready,
    output req_ready, resp_valid, resp_data
  );

endinterface

`default_nettype wire

/* logic/red_lane_sync.sv */
// Lane sync that forks one request handshake to all lanes and joins their responses

`timescale 1ns/1ps
`default_nettype none

`include "red_defines.svh"

module red_lane_sync (
  input  logic        clk_i,
  input  logic        arst_n_i,
  input  logic        flush_i,
  input  logic        valid_i,
  output logic        ready_o,
  output logic        resp_valid_o,
  input  logic        resp_ready_i,
  red_lane_if.sync    lanes [`RED_LANES]
);

  // One bit per lane, set once that lane has taken the current request
  logic [`RED_LANES-1:0] taken_q;
  logic [`RED_LANES-1:0] taken_d;

  // Flattened lane handshake signals
  logic [`RED_LANES-1:0] lane_req_ready;
  logic [`RED_LANES-1:0] lane_resp_valid;

  for (genvar i = 0; i < `RED_LANES; i++) begin : gen_lane_hs
    // A lane that already holds the request sees no valid again
    assign lanes[i].req_valid  = valid_i & ~taken_q[i];
    assign lane_req_ready[i]   = lanes[i].req_ready;

    assign lane_resp_valid[i]  = lanes[i].resp_valid;
    // All lanes release their result on the same edge
    assign lanes[i].resp_ready = resp_ready_i & resp_valid_o;
  end

  // Fork completes once every lane has it or takes it now
  assign ready_o = &(taken_q | lane_req_ready);

  // Join
  assign resp_valid_o = &lane_resp_valid;

  always_comb begin
    taken_d = taken_q;
    if (valid_i) begin
      if (ready_o) begin
        // Request done, start fresh for the next one
        taken_d = '0;
      end else begin
        taken_d = taken_q | lane_req_ready;
      end
    end
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      taken_q <= '0;
    end else if (flush_i) begin
      taken_q <= '0;
    end else begin
      taken_q <= taken_d;
    end
  end

endmodule

`default_nettype wire

/* red_alu/red_alu_lane.sv */
// Reduction ALU lane with a two-stage pipeline and valid/ready flow control

`timescale 1ns/1ps
`default_nettype none

module red_alu_lane (
  input  logic     clk_i,
  input  logic     arst_n_i,
  input  logic     flush_i,
  red_lane_if.lane lane_io
);

  import red_pkg::*;

  // Stage one, registered operands and operation
  logic       s1_valid_q;
  lane_data_t s1_op1_q;
  lane_data_t s1_op2_q;
  red_op_e    s1_op_q;

  // Stage two, registered result
  logic       s2_valid_q;
  lane_data_t s2_data_q;

  // Flow control
  logic       s2_free;
  logic       s1_move;
  logic       req_fire;

  lane_data_t alu_result;

  // Stage two can take new data when empty or handing off this cycle
  assign s2_free  = ~s2_valid_q | lane_io.resp_ready;
  assign s1_move  = s1_valid_q & s2_free;

  // Stage one accepts when empty or moving on
  assign lane_io.req_ready = ~s1_valid_q | s2_free;
  assign req_fire          = lane_io.req_valid & lane_io.req_ready;

  // Reduction operation on the stage-one operands
  always_comb begin
    alu_result = '0;
    unique case (s1_op_q)
      ADD:  alu_result = s1_op1_q + s1_op2_q;
      MUL:  alu_result = s1_op1_q * s1_op2_q;
      MAX:  alu_result = ($signed(s1_op1_q) > $signed(s1_op2_q)) ? s1_op1_q : s1_op2_q;
      MIN:  alu_result = ($signed(s1_op1_q) < $signed(s1_op2_q)) ? s1_op1_q : s1_op2_q;
      MAXU: alu_result = (s1_op1_q > s1_op2_q) ? s1_op1_q : s1_op2_q;
      MINU: alu_result = (s1_op1_q < s1_op2_q) ? s1_op1_q : s1_op2_q;
      AND:  alu_result = s1_op1_q & s1_op2_q;
      OR:   alu_result = s1_op1_q | s1_op2_q;
      default: alu_result = '0;
    endcase
  end

  // Stage-one valid
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      s1_valid_q <= 1'b0;
    end else if (flush_i) begin
      s1_valid_q <= 1'b0;
    end else if (lane_io.req_ready) begin
      s1_valid_q <= lane_io.req_valid;
    end
  end

  // Stage-one payload
  always_ff @(posedge clk_i) begin
    if (req_fire) begin
      s1_op1_q <= lane_io.req_op1;
      s1_op2_q <= lane_io.req_op2;
      s1_op_q  <= lane_io.req_op;
    end
  end

  // Stage-two valid
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      s2_valid_q <= 1'b0;
    end else if (flush_i) begin
      s2_valid_q <= 1'b0;
    end else if (s2_free) begin
      s2_valid_q <= s1_valid_q;
    end
  end

  // Stage-two result, held while the response waits
  always_ff @(posedge clk_i) begin
    if (s1_move) begin
      s2_data_q <= alu_result;
    end
  end

  assign lane_io.resp_valid = s2_valid_q;
  assign lane_io.resp_data  = s2_data_q;

endmodule

`default_nettype wire

/* red_alu/red_reduction_unit.sv */
// Lane-parallel integer reduction unit with fork/join handshake over all lanes

`timescale 1ns/1ps
`default_nettype none

`include "red_defines.svh"

module red_reduction_unit (
  input  logic                                clk_i,
  input  logic                                arst_n_i,
  input  logic                                flush_i,
  // Request
  input  logic [`RED_LANES*`RED_LANE_W-1:0]   op1_i,
  input  logic [`RED_LANES*`RED_LANE_W-1:0]   op2_i,
  input  red_pkg::red_op_e                    op_i,
  input  logic                                valid_i,
  output logic                                ready_o,
  // Response
  output logic [`RED_LANES*`RED_LANE_W-1:0]   resp_data_o,
  output logic                                resp_valid_o,
  input  logic                                resp_ready_i
);

  // One stream bundle per lane
  red_lane_if lane_if [`RED_LANES] ();

  // Fork and join of the handshakes
  red_lane_sync i_sync (
    .clk_i        (clk_i),
    .arst_n_i     (arst_n_i),
    .flush_i      (flush_i),
    .valid_i      (valid_i),
    .ready_o      (ready_o),
    .resp_valid_o (resp_valid_o),
    .resp_ready_i (resp_ready_i),
    .lanes        (lane_if)
  );

  for (genvar g = 0; g < `RED_LANES; g++) begin : gen_lane

    // Operand slices for this lane, op is shared
    assign lane_if[g].req_op1 = op1_i[g*`RED_LANE_W +: `RED_LANE_W];
    assign lane_if[g].req_op2 = op2_i[g*`RED_LANE_W +: `RED_LANE_W];
    assign lane_if[g].req_op  = op_i;

    red_alu_lane i_lane (
      .clk_i    (clk_i),
      .arst_n_i (arst_n_i),
      .flush_i  (flush_i),
      .lane_io  (lane_if[g])
    );

    // Lane g lands in slice g of the wide response
    assign resp_data_o[g*`RED_LANE_W +: `RED_LANE_W] = lane_if[g].resp_data;

  end

endmodule

`default_nettype wire

/* dv/red_asserts.sv */
// Handshake assertions for the reduction unit, bound to the top level

`timescale 1ns/1ps
`default_nettype none

`include "red_defines.svh"

module red_asserts (
  input logic                                clk_i,
  input logic                                arst_n_i,
  input logic                                flush_i,
  input logic                                valid_i,
  input logic                                ready_i,
  input logic                                resp_valid_i,
  input logic                                resp_ready_i,
  input logic [`RED_LANES*`RED_LANE_W-1:0]   resp_data_i
);

  // Number of failed assertions
  int fail_cnt = 0;

  // A waiting response keeps its valid
  resp_valid_held: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    resp_valid_i && !resp_ready_i && !flush_i |=> resp_valid_i)
    else begin
      $error("resp_valid_o dropped before its transfer");
      fail_cnt++;
    end

  // and its data
  resp_data_stable: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    resp_valid_i && !resp_ready_i && !flush_i |=> $stable(resp_data_i))
    else begin
      $error("resp_data_o changed while the response was waiting");
      fail_cnt++;
    end

  // Request side of the same rule
  req_valid_held: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    valid_i && !ready_i && !flush_i |=> valid_i)
    else begin
      $error("valid_i dropped before the request was accepted");
      fail_cnt++;
    end

  // Flush empties both stages of every lane
  flush_clears_resp: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    flush_i |=> !resp_valid_i)
    else begin
      $error("resp_valid_o still high in the cycle after a flush");
      fail_cnt++;
    end

endmodule

bind red_reduction_unit red_asserts u_asserts (
  .clk_i        (clk_i),
  .arst_n_i     (arst_n_i),
  .flush_i      (flush_i),
  .valid_i      (valid_i),
  .ready_i      (ready_o),
  .resp_valid_i (resp_valid_o),
  .resp_ready_i (resp_ready_i),
  .resp_data_i  (resp_data_o)
);

`default_nettype wire

/* dv/red_checker.sv */
// Reduction unit monitor that predicts each wide result and compares responses

`timescale 1ns/1ps
`default_nettype none

`include "red_defines.svh"

module red_checker (
  input  logic                                clk_i,
  input  logic                                arst_n_i,
  input  logic                                flush_i,
  input  logic [`RED_LANES*`RED_LANE_W-1:0]   op1_i,
  input  logic [`RED_LANES*`RED_LANE_W-1:0]   op2_i,
  input  red_pkg::red_op_e                    op_i,
  input  logic                                valid_i,
  input  logic                                ready_i,
  input  logic [`RED_LANES*`RED_LANE_W-1:0]   resp_data_i,
  input  logic                                resp_valid_i,
  input  logic                                resp_ready_i,
  input  logic                                timing_check_i,
  output int                                  data_errors_o,
  output int                                  other_errors_o,
  output int                                  pending_o
);

  import red_pkg::*;

  localparam int W = `RED_LANE_W;

  typedef logic [`RED_LANES*`RED_LANE_W-1:0] wide_t;

  wide_t exp_q [$];
  int    acc_q [$];
  int    cycle_cnt = 0;

  // Expected lane value straight from the operation definitions
  function automatic lane_data_t lane_expect(red_op_e op, lane_data_t a, lane_data_t b);
    longint sa;
    longint sb;
    sa = a;
    sb = b;
    case (op)
      ADD:     return a + b;
      MUL:     return a * b;
      MAX:     return (sa >= sb) ? a : b;
      MIN:     return (sa <= sb) ? a : b;
      MAXU:    return (a >= b) ? a : b;
      MINU:    return (a <= b) ? a : b;
      AND:     return a & b;
      OR:      return a | b;
      default: return '0;
    endcase
  endfunction

  function automatic wide_t wide_expect(red_op_e op, wide_t a, wide_t b);
    wide_t r;
    r = '0;
    for (int i = 0; i < `RED_LANES; i++) begin
      r[i*W +: W] = lane_expect(op, a[i*W +: W], b[i*W +: W]);
    end
    return r;
  endfunction

  always @(posedge clk_i) begin
    wide_t exp_data;
    int    acc_cycle;
    cycle_cnt = cycle_cnt + 1;
    if (!arst_n_i) begin
      exp_q.delete();
      acc_q.delete();
      data_errors_o  = 0;
      other_errors_o = 0;
    end else if (flush_i) begin
      // Everything in flight is dropped by the DUT
      exp_q.delete();
      acc_q.delete();
    end else begin
      if (resp_valid_i && resp_ready_i) begin
        if (exp_q.size() == 0) begin
          other_errors_o = other_errors_o + 1;
          $display("Response at %0t arrived with no request outstanding", $time);
        end else begin
          exp_data  = exp_q.pop_front();
          acc_cycle = acc_q.pop_front();
          if (resp_data_i !== exp_data) begin
            data_errors_o = data_errors_o + 1;
            $display("** Error at %0t: resp_data_o expected %h, got %h",
                     $time, exp_data, resp_data_i);
          end
          if (timing_check_i && (cycle_cnt - acc_cycle) != 2) begin
            other_errors_o = other_errors_o + 1;
            $display("Response at %0t came %0d edges after its request instead of 2",
                     $time, cycle_cnt - acc_cycle);
          end
        end
      end
      if (valid_i && ready_i) begin
        exp_q.push_back(wide_expect(op_i, op1_i, op2_i));
        acc_q.push_back(cycle_cnt);
      end
    end
    pending_o <= exp_q.size();
  end

endmodule

`default_nettype wire

/* dv/red_tb.sv */
// Reduction unit testbench with a stimulus table, back-pressure and a watchdog

`timescale 1ns/1ps
`default_nettype none

`include "red_defines.svh"

module red_tb;

  import red_pkg::*;

  localparam int CLK_PERIOD   = 8;
  localparam int RESET_CYCLES = 10;
  localparam int STIM_LEN     = 14;
  // Two passes over the table
  localparam int LIMIT_CYCLES = 2 * STIM_LEN * 20 + RESET_CYCLES;

  typedef logic [`RED_LANES*`RED_LANE_W-1:0] wide_t;

  typedef struct packed {
    red_op_e    op;
    lane_data_t a;
    lane_data_t b;
    logic       flush;
  } entry_t;

  logic    clk_i;
  logic    arst_n_i;
  logic    flush_i;
  wide_t   op1_i;
  wide_t   op2_i;
  red_op_e op_i;
  logic    valid_i;
  logic    ready_o;
  wide_t   resp_data_o;
  logic    resp_valid_o;
  logic    resp_ready_i;

  entry_t stim [STIM_LEN];
  int     seed = 57;
  int     rnd;
  logic   rand_bp;
  logic   timing_check;
  int     tb_errors;
  int     data_errs;
  int     other_errs;
  int     pending;

  red_reduction_unit dut0 (
    .clk_i        (clk_i),
    .arst_n_i     (arst_n_i),
    .flush_i      (flush_i),
    .op1_i        (op1_i),
    .op2_i        (op2_i),
    .op_i         (op_i),
    .valid_i      (valid_i),
    .ready_o      (ready_o),
    .resp_data_o  (resp_data_o),
    .resp_valid_o (resp_valid_o),
    .resp_ready_i (resp_ready_i)
  );

  red_checker u_checker (
    .clk_i          (clk_i),
    .arst_n_i       (arst_n_i),
    .flush_i        (flush_i),
    .op1_i          (op1_i),
    .op2_i          (op2_i),
    .op_i           (op_i),
    .valid_i        (valid_i),
    .ready_i        (ready_o),
    .resp_data_i    (resp_data_o),
    .resp_valid_i   (resp_valid_o),
    .resp_ready_i   (resp_ready_i),
    .timing_check_i (timing_check),
    .data_errors_o  (data_errs),
    .other_errors_o (other_errs),
    .pending_o      (pending)
  );

  initial begin
    clk_i = 1'b0;
    forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
  end

  // Back-pressure, random or held high
  always @(posedge clk_i) begin
    #1;
    rnd = $random(seed);
    resp_ready_i = rand_bp ? rnd[0] : 1'b1;
  end

  initial begin
    #(LIMIT_CYCLES * CLK_PERIOD);
    $display("Timeout, the run did not finish within %0d cycles", LIMIT_CYCLES);
    $display("sim failed");
    $finish;
  end

  // Distinct lanes, odd lanes of op2 flip sign
  function automatic wide_t spread_a(lane_data_t base);
    wide_t w;
    for (int i = 0; i < `RED_LANES; i++) begin
      w[i*`RED_LANE_W +: `RED_LANE_W] = base + 64'(i) * 64'h1111;
    end
    return w;
  endfunction

  function automatic wide_t spread_b(lane_data_t base);
    wide_t w;
    for (int i = 0; i < `RED_LANES; i++) begin
      w[i*`RED_LANE_W +: `RED_LANE_W] = i[0] ? ~base : base + 64'(i);
    end
    return w;
  endfunction

  task automatic fill_stimulus();
    stim[0]  = '{ADD,  64'h0000_0000_0000_0005, 64'h0000_0000_0000_0007, 1'b0};
    stim[1]  = '{ADD,  64'hFFFF_FFFF_FFFF_FFFF, 64'h0000_0000_0000_0002, 1'b0};
    stim[2]  = '{MUL,  64'h0000_0001_0000_0003, 64'h0000_0002_0000_0005, 1'b0};
    stim[3]  = '{MUL,  64'h8000_0000_0000_0001, 64'hFFFF_FFFF_0000_0003, 1'b0};
    stim[4]  = '{MAX,  64'hFFFF_FFFF_FFFF_FFF0, 64'h0000_0000_0000_0010, 1'b0};
    stim[5]  = '{MIN,  64'hFFFF_FFFF_FFFF_FFF0, 64'h0000_0000_0000_0010, 1'b0};
    stim[6]  = '{MAXU, 64'hFFFF_FFFF_FFFF_FFF0, 64'h0000_0000_0000_0010, 1'b0};
    stim[7]  = '{MINU, 64'hFFFF_FFFF_FFFF_FFF0, 64'h0000_0000_0000_0010, 1'b0};
    // Drops the two requests still in the pipeline
    stim[8]  = '{ADD,  64'h0, 64'h0, 1'b1};
    stim[9]  = '{AND,  64'hF0F0_F0F0_0F0F_0F0F, 64'h0FF0_0FF0_FF00_FF00, 1'b0};
    stim[10] = '{OR,   64'h1234_5678_9ABC_DEF0, 64'h8000_0000_0000_0001, 1'b0};
    stim[11] = '{MAX,  64'h7FFF_FFFF_FFFF_FFFF, 64'h8000_0000_0000_0000, 1'b0};
    stim[12] = '{MINU, 64'h8000_0000_0000_0000, 64'h7FFF_FFFF_FFFF_FFFF, 1'b0};
    stim[13] = '{MIN,  64'h8000_0000_0000_0005, 64'h0000_0000_0000_0003, 1'b0};
  endtask

  task automatic send_request(input entry_t e, input logic back_to_back);
    int waits;
    waits   = 0;
    op_i    = e.op;
    op1_i   = spread_a(e.a);
    op2_i   = spread_b(e.b);
    valid_i = 1'b1;
    do begin
      @(posedge clk_i);
      waits++;
    end while (!ready_o);
    #1;
    valid_i = 1'b0;
    if (back_to_back && waits != 1) begin
      tb_errors++;
      $display("Request at %0t needed %0d cycles to be accepted instead of 1", $time, waits);
    end
  endtask

  task automatic pulse_flush();
    flush_i = 1'b1;
    @(posedge clk_i);
    #1;
    flush_i = 1'b0;
  endtask

  task automatic run_table(input logic back_to_back);
    for (int k = 0; k < STIM_LEN; k++) begin
      if (stim[k].flush) begin
        pulse_flush();
      end else begin
        send_request(stim[k], back_to_back);
      end
    end
  endtask

  // Wait until every accepted request has answered
  task automatic drain();
    do @(posedge clk_i); while (pending != 0);
    #1;
  endtask

  initial begin
    arst_n_i     = 1'b0;
    flush_i      = 1'b0;
    op1_i        = '0;
    op2_i        = '0;
    op_i         = ADD;
    valid_i      = 1'b0;
    resp_ready_i = 1'b1;
    rand_bp      = 1'b0;
    timing_check = 1'b0;
    tb_errors    = 0;
    fill_stimulus();
    repeat (RESET_CYCLES) @(posedge clk_i);
    #1;
    arst_n_i = 1'b1;
    if (resp_valid_o !== 1'b0) begin
      tb_errors++;
      $display("** Error at %0t: resp_valid_o expected 0, got %b", $time, resp_valid_o);
    end
    // Pass one with resp_ready_i high, one request per cycle and fixed latency
    timing_check = 1'b1;
    run_table(1'b1);
    drain();
    timing_check = 1'b0;
    // Pass two under random back-pressure
    rand_bp = 1'b1;
    run_table(1'b0);
    rand_bp = 1'b0;
    drain();
    $display("Errors: data %0d, other %0d, assertion %0d, testbench %0d",
             data_errs, other_errs, dut0.u_asserts.fail_cnt, tb_errors);
    if (data_errs + other_errs + dut0.u_asserts.fail_cnt + tb_errors == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* build.f */
+incdir+common
common/red_pkg.sv
common/red_lane_if.sv
logic/red_lane_sync.sv
red_alu/red_alu_lane.sv
red_alu/red_reduction_unit.sv
dv/red_asserts.sv
dv/red_checker.sv
dv/red_tb.sv

/* Makefile */
# Verilator simulation of the reduction unit testbench

VERILATOR ?= verilator
TOP       ?= red_tb
FILELIST  ?= build.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "sim passed"

clean:
	rm -rf $(OBJ_DIR)
